// File: common/mont_pkg.sv
`default_nettype none

package mont_pkg;

	// Operand size
	localparam int WORDS      = 4;
	localparam int BITS       = WORDS * 32;
	localparam int WORD_IDX_W = $clog2(WORDS);

	// Loop counter also counts fetched words, so it needs BITS in range
	localparam int BIT_CNT_W  = $clog2(BITS) + 1;

	// Command queue
	localparam int CMD_DEPTH  = 4;
	localparam int CMD_PTR_W  = $clog2(CMD_DEPTH);

	// Byte addresses of one Montgomery command
	typedef struct packed {
		logic [31:0] a_addr;
		logic [31:0] b_addr;
		logic [31:0] n_addr;
		logic [31:0] res_addr;
	} mont_cmd_t;

endpackage

`default_nettype wire

// File: common/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

	// Scratch memory depth in 32-bit words
	localparam int MEM_WORDS  = 64;
	localparam int MEM_IDX_W  = $clog2(MEM_WORDS);

	// Byte address to word index
	localparam int BYTE_SHIFT = 2;

endpackage

`default_nettype wire

// File: common/lsu_if.sv
`timescale 1ns/1ps
`default_nettype none

interface lsu_if;

	logic        ren;
	logic        wen;
	logic [31:0] addr_base;
	logic [31:0] addr_offset;
	logic        done;
	logic [31:0] rdata;
	logic [31:0] wdata;

	// Engine side
	modport master (
		output ren,
		output wen,
		output addr_base,
		output addr_offset,
		output wdata,
		input  done,
		input  rdata
	);

	// Memory side
	modport slave (
		input  ren,
		input  wen,
		input  addr_base,
		input  addr_offset,
		input  wdata,
		output done,
		output rdata
	);

endinterface

`default_nettype wire

// File: verilog/cmd_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo import mont_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      push,
	input  mont_cmd_t wdata,
	output logic      full,
	input  logic      pop,
	output mont_cmd_t head,
	output logic      not_empty
);

	mont_cmd_t slots [CMD_DEPTH];

	logic [CMD_PTR_W-1:0] wr_ptr;
	logic [CMD_PTR_W-1:0] rd_ptr;
	logic [CMD_PTR_W:0]   count;
	logic                 do_push;
	logic                 do_pop;

	// Ignore a push into a full queue or a pop from an empty one
	assign do_push = push && !full;
	assign do_pop  = pop && not_empty;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_push)
			slots[wr_ptr] <= wdata;
	end

	assign head      = slots[rd_ptr];
	assign full      = (count == (CMD_PTR_W + 1)'(CMD_DEPTH));
	assign not_empty = (count != '0);

endmodule

`default_nettype wire

// File: mont_mul/mont_issue.sv
`timescale 1ns/1ps
`default_nettype none

module mont_issue import mont_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        not_empty,
	input  mont_cmd_t   head,
	output logic        pop,
	output logic        start,
	output logic [31:0] addr_0,
	output logic [31:0] addr_1,
	input  logic        engine_done,
	output logic        busy
);

	typedef enum logic [1:0] {
		st_idle,
		st_addr_2,
		st_wait
	} state_t;

	state_t      state;
	logic [31:0] n_addr_q;
	logic [31:0] res_addr_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:   if (not_empty) state <= st_addr_2;
				st_addr_2: state <= st_wait;
				st_wait:   if (engine_done) state <= st_idle;
				default:   state <= st_idle;
			endcase
		end
	end

	// Second half of the command, kept for the next cycle since the head is popped
	always_ff @(posedge clk) begin
		if (state == st_idle && not_empty) begin
			n_addr_q   <= head.n_addr;
			res_addr_q <= head.res_addr;
		end
	end

	always_comb begin
		pop    = 1'b0;
		start  = 1'b0;
		addr_0 = head.a_addr;
		addr_1 = head.b_addr;
		case (state)
			st_idle: begin
				pop   = not_empty;
				start = not_empty;
			end
			st_addr_2: begin
				start  = 1'b1;
				addr_0 = n_addr_q;
				addr_1 = res_addr_q;
			end
			default: ;
		endcase
	end

	assign busy = (state != st_idle);

endmodule

`default_nettype wire

// File: mont_mul/mont_mul.sv
`timescale 1ns/1ps
`default_nettype none

module mont_mul import mont_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        start,
	input  logic [31:0] addr_0,
	input  logic [31:0] addr_1,
	lsu_if.master       lsu,
	output logic        done
);

	typedef enum logic [2:0] {
		st_idle,
		st_prepare,
		st_fetch,
		st_run_1,
		st_run_2,
		st_cleanup,
		st_finish
	} state_t;

	state_t               state;
	state_t               state_n;
	logic [BIT_CNT_W-1:0] counter;
	logic [BIT_CNT_W-1:0] counter_n;

	// Operands and their byte addresses
	logic [BITS-1:0] a;
	logic [BITS-1:0] b;
	logic [BITS-1:0] n;
	logic [31:0]     a_addr;
	logic [31:0]     b_addr;
	logic [31:0]     n_addr;
	logic [31:0]     res_addr;

	// Accumulator with two guard bits, M + B + N stays below 4N
	logic [BITS+1:0] m;
	logic [BITS+1:0] m_n;
	logic [BITS+1:0] m_sel;
	logic [BITS+1:0] add_in;
	logic            carry;
	logic [BITS+2:0] sum;

	logic [WORD_IDX_W-1:0] word_idx;
	logic [1:0]            fetch_sel;

	logic        ren;
	logic        wen;
	logic [31:0] addr_base;
	logic [31:0] addr_offset;
	logic [31:0] wdata;

	// The one adder shared by the loop and the final subtraction
	assign sum = {1'b0, m} + {1'b0, add_in} + {{(BITS + 2){1'b0}}, carry};

	// Low counter bits pick the word, the next two pick A, B or N
	assign word_idx  = counter[WORD_IDX_W-1:0];
	assign fetch_sel = counter[WORD_IDX_W +: 2];

	always_ff @(posedge clk) begin
		if (start && state == st_idle) begin
			a_addr <= addr_0;
			b_addr <= addr_1;
		end
		if (start && state == st_prepare) begin
			n_addr   <= addr_0;
			res_addr <= addr_1;
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_fetch && lsu.done) begin
			case (fetch_sel)
				2'd0:    a[{word_idx, 5'd0} +: 32] <= lsu.rdata;
				2'd1:    b[{word_idx, 5'd0} +: 32] <= lsu.rdata;
				2'd2:    n[{word_idx, 5'd0} +: 32] <= lsu.rdata;
				default: ;
			endcase
		end else if (state == st_run_2) begin
			a <= a >> 1;
		end
		m <= m_n;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= st_idle;
			counter <= '0;
		end else begin
			state   <= state_n;
			counter <= counter_n;
		end
	end

	always_comb begin
		state_n     = state;
		counter_n   = counter;
		m_n         = m;
		m_sel       = m;
		add_in      = {2'b00, b};
		carry       = 1'b0;
		ren         = 1'b0;
		wen         = 1'b0;
		addr_base   = a_addr;
		addr_offset = '0;
		wdata       = '0;
		done        = 1'b0;

		case (state)
			st_idle: begin
				m_n       = '0;
				counter_n = '0;
				if (start)
					state_n = st_prepare;
			end
			// N and result addresses arrive on this cycle
			st_prepare: state_n = st_fetch;
			st_fetch: begin
				ren = 1'b1;
				if (lsu.done) begin
					counter_n = counter + 1'b1;
					if (counter == BIT_CNT_W'(3 * WORDS - 1)) begin
						counter_n = '0;
						ren       = 1'b0;
						state_n   = st_run_1;
					end
				end
				// Next address goes out in the done cycle
				case (counter_n[WORD_IDX_W +: 2])
					2'd1:    addr_base = b_addr;
					2'd2:    addr_base = n_addr;
					default: addr_base = a_addr;
				endcase
				addr_offset = {{(30 - WORD_IDX_W){1'b0}}, counter_n[WORD_IDX_W-1:0], 2'b00};
			end
			st_run_1: begin
				// M + B when the current A bit is set
				if (a[0])
					m_n = sum[BITS+1:0];
				state_n = st_run_2;
			end
			st_run_2: begin
				add_in = {2'b00, n};
				if (m[0])
					m_sel = sum[BITS+1:0];
				m_n       = m_sel >> 1;
				counter_n = counter + 1'b1;
				state_n   = counter_n[BIT_CNT_W-1] ? st_cleanup : st_run_1;
			end
			st_cleanup: begin
				add_in = ~{2'b00, n};
				carry  = 1'b1;
				// Carry out means M >= N
				if (sum[BITS+2])
					m_n = sum[BITS+1:0];
				// Write-back counts words from zero
				counter_n = '0;
				state_n   = st_finish;
			end
			st_finish: begin
				wen         = 1'b1;
				addr_base   = res_addr;
				addr_offset = {{(30 - WORD_IDX_W){1'b0}}, word_idx, 2'b00};
				wdata       = m[{word_idx, 5'd0} +: 32];
				counter_n   = counter + 1'b1;
				if (counter == BIT_CNT_W'(WORDS)) begin
					wen       = 1'b0;
					done      = 1'b1;
					counter_n = '0;
					state_n   = st_idle;
				end
			end
			default: state_n = st_idle;
		endcase
	end

	assign lsu.ren         = ren;
	assign lsu.wen         = wen;
	assign lsu.addr_base   = addr_base;
	assign lsu.addr_offset = addr_offset;
	assign lsu.wdata       = wdata;

endmodule

`default_nettype wire

// File: verilog/scratch_mem.sv
`timescale 1ns/1ps
`default_nettype none

module scratch_mem import lsu_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	lsu_if.slave                 lsu,
	input  logic                 host_wen,
	input  logic [MEM_IDX_W-1:0] host_addr,
	input  logic [31:0]          host_wdata,
	output logic [31:0]          host_rdata
);

	logic [31:0] mem [MEM_WORDS];

	logic [31:0]          byte_addr;
	logic [MEM_IDX_W-1:0] lsu_idx;
	logic                 pending;
	logic [31:0]          rdata_q;
	logic                 host_blocked;

	// Word index wraps at MEM_WORDS
	assign byte_addr = lsu.addr_base + lsu.addr_offset;
	assign lsu_idx   = byte_addr[BYTE_SHIFT +: MEM_IDX_W];

	// LSU write wins when both ports hit one word
	assign host_blocked = lsu.wen && (lsu_idx == host_addr);

	// High in the done cycle, so ren is not sampled again until the cycle after
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pending <= 1'b0;
		else
			pending <= lsu.ren && !pending;
	end

	always_ff @(posedge clk) begin
		if (lsu.ren && !pending)
			rdata_q <= mem[lsu_idx];
		host_rdata <= mem[host_addr];
		if (host_wen && !host_blocked)
			mem[host_addr] <= host_wdata;
		if (lsu.wen)
			mem[lsu_idx] <= lsu.wdata;
	end

	assign lsu.done  = pending;
	assign lsu.rdata = rdata_q;

endmodule

`default_nettype wire

// File: verilog/mont_accel.sv
`timescale 1ns/1ps
`default_nettype none

module mont_accel import mont_pkg::*, lsu_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 cmd_valid,
	input  logic [31:0]          cmd_a_addr,
	input  logic [31:0]          cmd_b_addr,
	input  logic [31:0]          cmd_n_addr,
	input  logic [31:0]          cmd_res_addr,
	output logic                 cmd_ready,
	input  logic                 host_wen,
	input  logic [MEM_IDX_W-1:0] host_addr,
	input  logic [31:0]          host_wdata,
	output logic [31:0]          host_rdata,
	output logic                 busy,
	output logic                 done
);

	mont_cmd_t   cmd_in;
	mont_cmd_t   head;
	logic        full;
	logic        not_empty;
	logic        pop;
	logic        start;
	logic [31:0] addr_0;
	logic [31:0] addr_1;

	lsu_if lsu ();

	assign cmd_in = '{
		a_addr:   cmd_a_addr,
		b_addr:   cmd_b_addr,
		n_addr:   cmd_n_addr,
		res_addr: cmd_res_addr
	};
	assign cmd_ready = !full;

	cmd_fifo u_cmd_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (cmd_valid && cmd_ready),
		.wdata     (cmd_in),
		.full      (full),
		.pop       (pop),
		.head      (head),
		.not_empty (not_empty)
	);

	mont_issue u_mont_issue (
		.clk         (clk),
		.rst_n       (rst_n),
		.not_empty   (not_empty),
		.head        (head),
		.pop         (pop),
		.start       (start),
		.addr_0      (addr_0),
		.addr_1      (addr_1),
		.engine_done (done),
		.busy        (busy)
	);

	mont_mul u_mont_mul (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (start),
		.addr_0 (addr_0),
		.addr_1 (addr_1),
		.lsu    (lsu.master),
		.done   (done)
	);

	scratch_mem u_scratch_mem (
		.clk        (clk),
		.rst_n      (rst_n),
		.lsu        (lsu.slave),
		.host_wen   (host_wen),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_rdata (host_rdata)
	);

endmodule

`default_nettype wire

// File: testbench/mont_accel_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module mont_accel_assertions (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic ren,
	input logic wen,
	input logic done
);

	// The engine never reads and writes memory in the same cycle
	a_no_read_write: assert property (@(posedge clk) disable iff (!rst_n)
		!(ren && wen))
		else $error("ren and wen high in the same cycle");

	// No third start cycle
	a_start_max: assert property (@(posedge clk) disable iff (!rst_n)
		start && $past(start) |-> !$past(start, 2))
		else $error("start held for more than two cycles");

	// Every start burst had two cycles before it fell
	a_start_min: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(start) |-> $past(start, 2))
		else $error("start held for fewer than two cycles");

	a_done_no_read: assert property (@(posedge clk) disable iff (!rst_n)
		!(done && ren))
		else $error("done high while ren is high");

endmodule

bind mont_mul mont_accel_assertions u_assertions (
	.clk   (clk),
	.rst_n (rst_n),
	.start (start),
	.ren   (ren),
	.wen   (wen),
	.done  (done)
);

`default_nettype wire

// File: testbench/tb_mont_accel.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mont_accel import mont_pkg::*, lsu_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 2000;
	localparam int DRIVE_DELAY    = 2;

	logic                 clk;
	logic                 rst_n;
	logic                 cmd_valid;
	logic [31:0]          cmd_a_addr;
	logic [31:0]          cmd_b_addr;
	logic [31:0]          cmd_n_addr;
	logic [31:0]          cmd_res_addr;
	logic                 cmd_ready;
	logic                 host_wen;
	logic [MEM_IDX_W-1:0] host_addr;
	logic [31:0]          host_wdata;
	logic [31:0]          host_rdata;
	logic                 busy;
	logic                 done;

	integer          seed;
	int              done_count;
	logic [31:0]     shadow [MEM_WORDS];
	logic [BITS-1:0] exp_res [8];
	int              res_slot [8];

	mont_accel u_dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.cmd_valid    (cmd_valid),
		.cmd_a_addr   (cmd_a_addr),
		.cmd_b_addr   (cmd_b_addr),
		.cmd_n_addr   (cmd_n_addr),
		.cmd_res_addr (cmd_res_addr),
		.cmd_ready    (cmd_ready),
		.host_wen     (host_wen),
		.host_addr    (host_addr),
		.host_wdata   (host_wdata),
		.host_rdata   (host_rdata),
		.busy         (busy),
		.done         (done)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Done pulses counted mid-cycle, where done is stable
	always @(negedge clk) begin
		if (!rst_n)
			done_count <= 0;
		else if (done)
			done_count <= done_count + 1;
	end

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	task automatic fail_now(input string what);
		$display("error: %s", what);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [BITS-1:0] actual,
		input logic [BITS-1:0] expected);
		if (actual !== expected) begin
			$display("mismatch %s: got %h expected %h", name, actual, expected);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic write_word(input int idx, input logic [31:0] data);
		host_wen    = 1'b1;
		host_addr   = MEM_IDX_W'(idx);
		host_wdata  = data;
		shadow[idx] = data;
		next_cycle();
		host_wen = 1'b0;
	endtask

	// Host read data is registered, so it shows up one cycle later
	task automatic read_word(input int idx, output logic [31:0] data);
		host_addr = MEM_IDX_W'(idx);
		next_cycle();
		data = host_rdata;
	endtask

	// Operands sit least significant word first, one slot per operand
	task automatic write_operand(input int slot, input logic [BITS-1:0] value);
		for (int i = 0; i < WORDS; i++)
			write_word(slot * WORDS + i, value[i*32 +: 32]);
	endtask

	task automatic read_result(input int slot, output logic [BITS-1:0] value);
		logic [31:0] word;
		value = '0;
		for (int i = 0; i < WORDS; i++) begin
			read_word(slot * WORDS + i, word);
			value[i*32 +: 32] = word;
		end
	endtask

	task automatic record_result(input int slot, input logic [BITS-1:0] value);
		for (int i = 0; i < WORDS; i++)
			shadow[slot * WORDS + i] = value[i*32 +: 32];
	endtask

	function automatic logic [31:0] fill_word(input int idx);
		return (32'(idx) * 32'h9E37_79B1) ^ 32'h5AC3_0F1E;
	endfunction

	function automatic logic [BITS-1:0] rand_wide();
		logic [BITS-1:0] value;
		for (int i = 0; i < WORDS; i++)
			value[i*32 +: 32] = $random(seed);
		return value;
	endfunction

	// Odd, with the top bit set
	function automatic logic [BITS-1:0] rand_modulus();
		logic [BITS-1:0] value;
		value          = rand_wide();
		value[BITS-1]  = 1'b1;
		value[0]       = 1'b1;
		return value;
	endfunction

	function automatic logic [BITS-1:0] rand_below(input logic [BITS-1:0] n);
		return rand_wide() % n;
	endfunction

	// A*B mod N, then divided by two BITS times using the inverse of 2 mod N
	function automatic logic [BITS-1:0] mont_model(input logic [BITS-1:0] a,
		input logic [BITS-1:0] b, input logic [BITS-1:0] n);
		logic [2*BITS-1:0] prod;
		logic [BITS:0]     x;
		prod = {{BITS{1'b0}}, a} * {{BITS{1'b0}}, b};
		x    = (BITS + 1)'(prod % {{BITS{1'b0}}, n});
		for (int i = 0; i < BITS; i++) begin
			if (x[0])
				x = x + {1'b0, n};
			x = x >> 1;
		end
		return x[BITS-1:0];
	endfunction

	// Random A, B and N at slot, slot + 1 and slot + 2
	task automatic prepare_set(input int slot, output logic [BITS-1:0] result);
		logic [BITS-1:0] a;
		logic [BITS-1:0] b;
		logic [BITS-1:0] n;
		n = rand_modulus();
		a = rand_below(n);
		b = rand_below(n);
		write_operand(slot, a);
		write_operand(slot + 1, b);
		write_operand(slot + 2, n);
		result = mont_model(a, b, n);
	endtask

	task automatic push_cmd(input int a_slot, input int b_slot, input int n_slot,
		input int r_slot);
		int waited;
		waited       = 0;
		cmd_a_addr   = 32'(a_slot * WORDS * 4);
		cmd_b_addr   = 32'(b_slot * WORDS * 4);
		cmd_n_addr   = 32'(n_slot * WORDS * 4);
		cmd_res_addr = 32'(r_slot * WORDS * 4);
		cmd_valid    = 1'b1;
		while (!cmd_ready) begin
			if (waited >= TIMEOUT_CYCLES) begin
				fail_now("timeout waiting for cmd_ready");
			end else begin
				next_cycle();
				waited++;
			end
		end
		next_cycle();
		cmd_valid = 1'b0;
	endtask

	task automatic wait_done(input int target);
		int waited;
		waited = 0;
		while (done_count < target) begin
			if (waited >= TIMEOUT_CYCLES) begin
				fail_now("timeout waiting for done");
			end else begin
				next_cycle();
				waited++;
			end
		end
	endtask

	task automatic wait_busy();
		int waited;
		waited = 0;
		while (!busy) begin
			if (waited >= TIMEOUT_CYCLES) begin
				fail_now("timeout waiting for busy");
			end else begin
				next_cycle();
				waited++;
			end
		end
	endtask

	// Results are read back right after each done, in issue order
	task automatic collect_results(input int base, input int count);
		logic [BITS-1:0] got;
		for (int k = 0; k < count; k++) begin
			wait_done(base + k + 1);
			read_result(res_slot[k], got);
			check_value($sformatf("result of command %0d", k), got, exp_res[k]);
			record_result(res_slot[k], exp_res[k]);
		end
	endtask

	task automatic check_memory();
		logic [31:0] word;
		for (int i = 0; i < MEM_WORDS; i++) begin
			read_word(i, word);
			check_value($sformatf("mem[%0d]", i), BITS'(word), BITS'(shadow[i]));
		end
	endtask

	initial begin
		logic [BITS-1:0] set_res [3];
		logic [BITS-1:0] n_val;
		logic [BITS-1:0] b_val;
		logic [BITS:0]   r_full;
		int              base;

		seed         = 69;
		rst_n        = 1'b0;
		cmd_valid    = 1'b0;
		cmd_a_addr   = '0;
		cmd_b_addr   = '0;
		cmd_n_addr   = '0;
		cmd_res_addr = '0;
		host_wen     = 1'b0;
		host_addr    = '0;
		host_wdata   = '0;

		repeat (16) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;

		check_value("cmd_ready", BITS'(cmd_ready), BITS'(1'b1));
		check_value("busy", BITS'(busy), BITS'(1'b0));
		check_value("done", BITS'(done), BITS'(1'b0));

		for (int i = 0; i < MEM_WORDS; i++)
			write_word(i, fill_word(i));

		// Single command
		base = done_count;
		prepare_set(0, exp_res[0]);
		res_slot[0] = 3;
		push_cmd(0, 1, 2, 3);
		collect_results(base, 1);

		// Four commands back to back, each with its own operands
		base = done_count;
		for (int k = 0; k < 4; k++) begin
			prepare_set(4 * k, exp_res[k]);
			res_slot[k] = 4 * k + 3;
		end
		for (int k = 0; k < 4; k++)
			push_cmd(4 * k, 4 * k + 1, 4 * k + 2, 4 * k + 3);
		collect_results(base, 4);

		// Fill the queue behind a running command, then hold one more
		base = done_count;
		for (int s = 0; s < 3; s++)
			prepare_set(4 * s, set_res[s]);
		res_slot[0] = 3;
		res_slot[1] = 7;
		res_slot[2] = 11;
		res_slot[3] = 12;
		res_slot[4] = 13;
		res_slot[5] = 14;
		for (int j = 0; j < 6; j++)
			exp_res[j] = set_res[j % 3];
		push_cmd(0, 1, 2, res_slot[0]);
		wait_busy();
		for (int j = 1; j < 5; j++)
			push_cmd(4 * (j % 3), 4 * (j % 3) + 1, 4 * (j % 3) + 2, res_slot[j]);
		check_value("cmd_ready", BITS'(cmd_ready), BITS'(1'b0));
		// A slot only frees once the running command is done and the next is popped
		push_cmd(8, 9, 10, res_slot[5]);
		check_value("done pulses before the held command got in",
			BITS'(done_count - base), BITS'(1));
		collect_results(base, 6);

		// A = 0 gives 0, A = 2^BITS mod N gives B
		base   = done_count;
		n_val  = rand_modulus();
		b_val  = rand_below(n_val);
		r_full = {1'b1, {BITS{1'b0}}};
		write_operand(0, n_val);
		write_operand(1, b_val);
		write_operand(2, '0);
		write_operand(4, BITS'(r_full % {1'b0, n_val}));
		exp_res[0]  = '0;
		res_slot[0] = 3;
		exp_res[1]  = b_val;
		res_slot[1] = 5;
		push_cmd(2, 1, 0, 3);
		push_cmd(4, 1, 0, 5);
		collect_results(base, 2);

		// No stray done pulses once everything has drained
		repeat (20) next_cycle();
		check_value("done pulse count", BITS'(done_count), BITS'(13));
		check_value("busy", BITS'(busy), BITS'(1'b0));
		check_memory();

		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: mont_accel.f
common/mont_pkg.sv
common/lsu_pkg.sv
common/lsu_if.sv
verilog/cmd_fifo.sv
mont_mul/mont_issue.sv
mont_mul/mont_mul.sv
verilog/scratch_mem.sv
verilog/mont_accel.sv
testbench/mont_accel_assertions.sv
testbench/tb_mont_accel.sv

// File: build.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_mont_accel \
	-Mdir obj_dir \
	-f mont_accel.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_mont_accel
status=$?
if [ $status -ne 0 ]; then
	echo "Testbench run exited with status $status"
	exit $status
fi
exit 0
